// File: hw/mtrap_pkg.sv
package mtrap_pkg;

  // ----------------------------------------
  // privilege modes
  // ----------------------------------------
  typedef enum logic [1:0] {
    mode_u = 2'd0,
    mode_m = 2'd3
  } priv_mode_t;

  // ----------------------------------------
  // csr addresses served by csr_file
  // ----------------------------------------
  typedef enum logic [11:0] {
    csr_mstatus       = 12'h300,
    csr_misa          = 12'h301,
    csr_mie           = 12'h304,
    csr_mtvec         = 12'h305,
    csr_mcounteren    = 12'h306,
    csr_mcountinhibit = 12'h320,
    csr_mscratch      = 12'h340,
    csr_mepc          = 12'h341,
    csr_mcause        = 12'h342,
    csr_mtval         = 12'h343,
    csr_mip           = 12'h344,
    csr_mcycle        = 12'hb00,
    csr_minstret      = 12'hb02,
    csr_mcycleh       = 12'hb80,
    csr_minstreth     = 12'hb82,
    csr_time          = 12'hc01, // read-only shadow of clint mtime.
    csr_timeh         = 12'hc81,
    csr_mvendorid     = 12'hf11,
    csr_marchid       = 12'hf12,
    csr_mimpid        = 12'hf13,
    csr_mhartid       = 12'hf14
  } csr_addr_t;

  // mxl = 1, extensions i, m, a, c.
  localparam logic [31:0] misa_value = 32'h4000_1105;

  // ----------------------------------------
  // interrupt cause codes
  // ----------------------------------------
  localparam logic [3:0] cause_m_soft   = 4'd3;
  localparam logic [3:0] cause_m_timer  = 4'd7;
  localparam logic [3:0] cause_m_extern = 4'd11;

  // ----------------------------------------
  // clint word offsets
  // ----------------------------------------
  localparam logic [3:0] clint_msip        = 4'h0;
  localparam logic [3:0] clint_mtimecmp_lo = 4'h2;
  localparam logic [3:0] clint_mtimecmp_hi = 4'h3;
  localparam logic [3:0] clint_mtime_lo    = 4'h4;
  localparam logic [3:0] clint_mtime_hi    = 4'h5;

  // compare never matches out of reset.
  localparam logic [63:0] mtimecmp_reset = 64'hffff_ffff_ffff_ffff;

endpackage

// File: hw/clint.sv
`timescale 1ns/1ps

module clint (
  input  logic        clk,
  input  logic        rst,
  input  logic        bus_wren,
  input  logic        bus_rden,
  input  logic [3:0]  bus_addr,
  input  logic [31:0] bus_wdata,
  output logic [31:0] bus_rdata,
  output logic        mtip,
  output logic        msip,
  output logic [63:0] mtime
);

  logic [63:0] mtimecmp;

  // ----------------------------------------
  // timer and software interrupt registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime    <= 64'b0;
      mtimecmp <= mtrap_pkg::mtimecmp_reset;
      msip     <= 1'b0;
      mtip     <= 1'b0;
    end else begin
      // bus write to mtime replaces the tick.
      if (bus_wren && bus_addr == mtrap_pkg::clint_mtime_lo) begin
        mtime <= {mtime[63:32], bus_wdata};
      end else if (bus_wren && bus_addr == mtrap_pkg::clint_mtime_hi) begin
        mtime <= {bus_wdata, mtime[31:0]};
      end else begin
        mtime <= mtime + 64'd1;
      end

      if (bus_wren) begin
        case (bus_addr)
          mtrap_pkg::clint_msip:        msip <= bus_wdata[0];
          mtrap_pkg::clint_mtimecmp_lo: mtimecmp[31:0] <= bus_wdata;
          mtrap_pkg::clint_mtimecmp_hi: mtimecmp[63:32] <= bus_wdata;
          default: ;
        endcase
      end

      mtip <= (mtime >= mtimecmp); // one cycle behind the compare.
    end
  end

  // ----------------------------------------
  // read port
  // ----------------------------------------
  always_comb begin
    bus_rdata = 32'b0;
    if (bus_rden) begin
      case (bus_addr)
        mtrap_pkg::clint_msip:        bus_rdata = {31'b0, msip};
        mtrap_pkg::clint_mtimecmp_lo: bus_rdata = mtimecmp[31:0];
        mtrap_pkg::clint_mtimecmp_hi: bus_rdata = mtimecmp[63:32];
        mtrap_pkg::clint_mtime_lo:    bus_rdata = mtime[31:0];
        mtrap_pkg::clint_mtime_hi:    bus_rdata = mtime[63:32];
        default:                      bus_rdata = 32'b0;
      endcase
    end
  end

endmodule

// File: hw/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rden,
  input  mtrap_pkg::csr_addr_t  raddr,
  input  logic                  wren,
  input  mtrap_pkg::csr_addr_t  waddr,
  input  logic [31:0]           wdata,
  input  logic                  valid,
  input  logic                  exc,
  input  logic [31:0]           epc,
  input  logic [31:0]           etval,
  input  logic [3:0]            ecause,
  input  logic                  mret_in,
  input  logic                  meip,
  input  logic                  mtip,
  input  logic                  msip,
  input  logic [63:0]           mtime,
  output logic [31:0]           rdata,
  output logic                  exc_taken,
  output logic                  mret_out,
  output mtrap_pkg::priv_mode_t mode,
  output logic [31:0]           mepc_out,
  output logic [31:0]           trap_vector
);

  // mstatus, machine fields only.
  logic                  mstatus_mie;
  logic                  mstatus_mpie;
  mtrap_pkg::priv_mode_t mstatus_mpp;

  logic mie_meie, mie_mtie, mie_msie;
  logic mip_meip, mip_mtip, mip_msip;

  logic [31:0] mtvec;
  logic [31:0] mscratch;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic [31:0] mtval;
  logic [63:0] mcycle;
  logic [63:0] minstret;
  logic [31:0] mcounteren;
  logic [31:0] mcountinhibit;

  logic        irq_ext, irq_tim, irq_sw;
  logic        trap;
  logic [3:0]  irq_code;
  logic [31:0] trap_cause;

  // ----------------------------------------
  // trap decision
  // ----------------------------------------
  assign irq_ext = mstatus_mie & mie_meie & mip_meip;
  assign irq_tim = mstatus_mie & mie_mtie & mip_mtip;
  assign irq_sw  = mstatus_mie & mie_msie & mip_msip;

  assign trap = exc | (valid & (irq_ext | irq_tim | irq_sw));

  always_comb begin
    if (irq_ext) begin
      irq_code = mtrap_pkg::cause_m_extern;
    end else if (irq_tim) begin
      irq_code = mtrap_pkg::cause_m_timer;
    end else begin
      irq_code = mtrap_pkg::cause_m_soft;
    end
  end

  // exceptions win over any pending interrupt.
  assign trap_cause = exc ? {28'b0, ecause} : {1'b1, 27'b0, irq_code};

  // ----------------------------------------
  // read port
  // ----------------------------------------
  always_comb begin
    rdata = 32'b0;
    if (rden) begin
      case (raddr)
        mtrap_pkg::csr_misa:          rdata = mtrap_pkg::misa_value;
        mtrap_pkg::csr_mvendorid:     rdata = 32'b0;
        mtrap_pkg::csr_marchid:       rdata = 32'b0;
        mtrap_pkg::csr_mimpid:        rdata = 32'b0;
        mtrap_pkg::csr_mhartid:       rdata = 32'b0; // single hart.
        mtrap_pkg::csr_mstatus:       rdata = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie,
                                               3'b0, mstatus_mie, 3'b0};
        mtrap_pkg::csr_mie:           rdata = {20'b0, mie_meie, 3'b0, mie_mtie,
                                               3'b0, mie_msie, 3'b0};
        mtrap_pkg::csr_mip:           rdata = {20'b0, mip_meip, 3'b0, mip_mtip,
                                               3'b0, mip_msip, 3'b0};
        mtrap_pkg::csr_mtvec:         rdata = mtvec;
        mtrap_pkg::csr_mscratch:      rdata = mscratch;
        mtrap_pkg::csr_mepc:          rdata = mepc;
        mtrap_pkg::csr_mcause:        rdata = mcause;
        mtrap_pkg::csr_mtval:         rdata = mtval;
        mtrap_pkg::csr_mcycle:        rdata = mcycle[31:0];
        mtrap_pkg::csr_mcycleh:       rdata = mcycle[63:32];
        mtrap_pkg::csr_minstret:      rdata = minstret[31:0];
        mtrap_pkg::csr_minstreth:     rdata = minstret[63:32];
        mtrap_pkg::csr_mcounteren:    rdata = mcounteren;
        mtrap_pkg::csr_mcountinhibit: rdata = mcountinhibit;
        mtrap_pkg::csr_time:          rdata = mtime[31:0];
        mtrap_pkg::csr_timeh:         rdata = mtime[63:32];
        default:                      rdata = 32'b0;
      endcase
    end
  end

  // ----------------------------------------
  // control state
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      mode          <= mtrap_pkg::mode_m;
      mstatus_mie   <= 1'b0;
      mstatus_mpie  <= 1'b0;
      mstatus_mpp   <= mtrap_pkg::mode_m;
      mie_meie      <= 1'b0;
      mie_mtie      <= 1'b0;
      mie_msie      <= 1'b0;
      mip_meip      <= 1'b0;
      mip_mtip      <= 1'b0;
      mip_msip      <= 1'b0;
      mtvec         <= 32'b0;
      mcause        <= 32'b0;
      mcycle        <= 64'b0;
      minstret      <= 64'b0;
      mcounteren    <= 32'b0;
      mcountinhibit <= 32'b0;
      exc_taken     <= 1'b0;
      mret_out      <= 1'b0;
    end else begin
      if (!mcountinhibit[0]) begin
        mcycle <= mcycle + 64'd1;
      end
      if (valid && !mcountinhibit[2]) begin
        minstret <= minstret + 64'd1;
      end

      // later assignments override the counter increments.
      if (wren) begin
        case (waddr)
          mtrap_pkg::csr_mstatus: begin
            mstatus_mie  <= wdata[3];
            mstatus_mpie <= wdata[7];
            if (wdata[12:11] == mtrap_pkg::mode_m || wdata[12:11] == mtrap_pkg::mode_u) begin
              mstatus_mpp <= mtrap_pkg::priv_mode_t'(wdata[12:11]);
            end
          end
          mtrap_pkg::csr_mie: begin
            mie_meie <= wdata[11];
            mie_mtie <= wdata[7];
            mie_msie <= wdata[3];
          end
          mtrap_pkg::csr_mtvec:         mtvec <= wdata;
          mtrap_pkg::csr_mcause:        mcause <= wdata;
          mtrap_pkg::csr_mcycle:        mcycle[31:0] <= wdata;
          mtrap_pkg::csr_mcycleh:       mcycle[63:32] <= wdata;
          mtrap_pkg::csr_minstret:      minstret[31:0] <= wdata;
          mtrap_pkg::csr_minstreth:     minstret[63:32] <= wdata;
          mtrap_pkg::csr_mcounteren:    mcounteren <= wdata;
          mtrap_pkg::csr_mcountinhibit: mcountinhibit <= wdata;
          default: ;
        endcase
      end

      mip_meip <= meip; // pins sampled every edge.
      mip_mtip <= mtip;
      mip_msip <= msip;

      if (trap) begin
        mstatus_mpie <= mstatus_mie;
        mstatus_mie  <= 1'b0;
        mstatus_mpp  <= mode;
        mode         <= mtrap_pkg::mode_m;
        mcause       <= trap_cause;
      end
      exc_taken <= trap;

      if (mret_in) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
        mode         <= mstatus_mpp;
        mstatus_mpp  <= mtrap_pkg::mode_u;
      end
      mret_out <= mret_in;
    end
  end

  // ----------------------------------------
  // payload registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wren && waddr == mtrap_pkg::csr_mscratch) begin
      mscratch <= wdata;
    end
    if (wren && waddr == mtrap_pkg::csr_mepc) begin
      mepc <= wdata;
    end
    if (wren && waddr == mtrap_pkg::csr_mtval) begin
      mtval <= wdata;
    end
    if (rst && trap) begin
      mepc  <= epc;
      mtval <= exc ? etval : 32'b0; // no trap value for interrupts.
    end
  end

  assign mepc_out = mepc;

  // vectored mode offsets by four per cause code.
  always_comb begin
    if (mtvec[1:0] == 2'b01) begin
      trap_vector = {mtvec[31:2] + {26'b0, mcause[3:0]}, 2'b00};
    end else begin
      trap_vector = {mtvec[31:2], 2'b00};
    end
  end

endmodule

// File: hw/mtrap_top.sv
`timescale 1ns/1ps

module mtrap_top (
  input  logic                  clk,
  input  logic                  rst,
  // csr port.
  input  logic                  rden,
  input  mtrap_pkg::csr_addr_t  raddr,
  input  logic                  wren,
  input  mtrap_pkg::csr_addr_t  waddr,
  input  logic [31:0]           wdata,
  input  logic                  valid,
  input  logic                  exc,
  input  logic [31:0]           epc,
  input  logic [31:0]           etval,
  input  logic [3:0]            ecause,
  input  logic                  mret_in,
  input  logic                  meip,
  output logic [31:0]           rdata,
  output logic                  exc_taken,
  output logic                  mret_out,
  output mtrap_pkg::priv_mode_t mode,
  output logic [31:0]           mepc_out,
  output logic [31:0]           trap_vector,
  // clint port.
  input  logic                  bus_wren,
  input  logic                  bus_rden,
  input  logic [3:0]            bus_addr,
  input  logic [31:0]           bus_wdata,
  output logic [31:0]           bus_rdata
);

  logic        mtip;
  logic        msip;
  logic [63:0] mtime;

  clint u_clint (
    .clk, .rst, .bus_wren, .bus_rden, .bus_addr, .bus_wdata,
    .bus_rdata, .mtip, .msip, .mtime
  );

  csr_file u_csr_file (
    .clk, .rst, .rden, .raddr, .wren, .waddr, .wdata, .valid,
    .exc, .epc, .etval, .ecause, .mret_in, .meip, .mtip, .msip, .mtime,
    .rdata, .exc_taken, .mret_out, .mode, .mepc_out, .trap_vector
  );

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period.
  end

  // active low, held over two rising edges.
  initial begin
    rst = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

// File: tests/mtrap_tb.sv
`timescale 1ns/1ps

module mtrap_tb;

  typedef enum {
    op_idle, op_valid, op_read, op_sample, op_read_delta, op_write, op_bus_wr,
    op_bus_rd, op_bus_delta, op_exc, op_mret, op_wait_trap, op_vec, op_mode, op_epc
  } op_t;

  // for op_exc, addr carries ecause and exp carries etval.
  typedef struct {
    op_t         op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [1:0]  flags; // expected {mret_out, exc_taken}.
  } step_t;

  logic                  clk, rst;
  logic                  rden, wren, valid, exc, mret_in, meip;
  mtrap_pkg::csr_addr_t  raddr, waddr;
  logic [31:0]           wdata, epc, etval, rdata, mepc_out, trap_vector;
  logic [3:0]            ecause;
  logic                  exc_taken, mret_out;
  mtrap_pkg::priv_mode_t mode;
  logic                  bus_wren, bus_rden;
  logic [3:0]            bus_addr;
  logic [31:0]           bus_wdata, bus_rdata;

  step_t       steps[$];
  logic [31:0] last_read;
  logic [11:0] zero_addrs [5] = '{mtrap_pkg::csr_mvendorid, mtrap_pkg::csr_marchid,
                                  mtrap_pkg::csr_mimpid, mtrap_pkg::csr_mhartid, 12'h7c0};
  int          errors = 0;
  int          cycles = 0;
  int          limit = 0;

  clock_gen u_clock_gen (.clk, .rst);

  mtrap_top UUT (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: the run went past %0d cycles without finishing", limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic clear_inputs();
    {rden, wren, valid, exc, mret_in, meip, bus_wren, bus_rden} <= 8'b0;
    raddr     <= mtrap_pkg::csr_misa;
    waddr     <= mtrap_pkg::csr_misa;
    {wdata, epc, etval, bus_wdata} <= 128'b0;
    ecause    <= 4'b0;
    bus_addr  <= 4'b0;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
  endtask

  task automatic add_step(input op_t op, input logic [11:0] addr, input logic [31:0] data,
                          input logic [31:0] exp, input logic [1:0] flags = 2'b00);
    steps.push_back(step_t'{op, addr, data, exp, flags});
  endtask

  task automatic add_write_read(input logic [11:0] addr, input logic [31:0] data,
                                input logic [31:0] exp);
    add_step(op_write, addr, data, 0);
    add_step(op_read, addr, 0, exp);
  endtask

  task automatic add_readback(input logic [11:0] addr);
    logic [31:0] value;
    value = $urandom;
    add_write_read(addr, value, value);
  endtask

  // ----------------------------------------
  // one table step, driven then checked
  // ----------------------------------------
  task automatic run_step(input step_t s);
    int waited;
    @(posedge clk);
    clear_inputs();
    case (s.op)
      op_valid, op_wait_trap: valid <= 1'b1;
      op_read, op_sample, op_read_delta: begin
        rden  <= 1'b1;
        raddr <= mtrap_pkg::csr_addr_t'(s.addr);
      end
      op_write: begin
        wren  <= 1'b1;
        waddr <= mtrap_pkg::csr_addr_t'(s.addr);
        wdata <= s.data;
      end
      op_bus_wr: begin
        bus_wren  <= 1'b1;
        bus_addr  <= s.addr[3:0];
        bus_wdata <= s.data;
      end
      op_bus_rd, op_bus_delta: begin
        bus_rden <= 1'b1;
        bus_addr <= s.addr[3:0];
      end
      op_exc: begin
        exc    <= 1'b1;
        epc    <= s.data;
        etval  <= s.exp;
        ecause <= s.addr[3:0];
      end
      op_mret: mret_in <= 1'b1;
      default: ;
    endcase
    @(negedge clk);
    if (s.op == op_wait_trap) begin
      waited = 0;
      while (exc_taken !== 1'b1 && waited < 20) begin
        @(negedge clk);
        waited++;
      end
      if (exc_taken !== 1'b1) begin
        errors++;
        $display("no interrupt was taken within 20 cycles of holding valid high");
      end
    end else begin
      if (exc_taken !== s.flags[0]) begin
        report_mismatch("exc_taken", {31'b0, exc_taken}, {31'b0, s.flags[0]});
      end
      if (mret_out !== s.flags[1]) begin
        report_mismatch("mret_out", {31'b0, mret_out}, {31'b0, s.flags[1]});
      end
    end
    if (s.op == op_read && rdata !== s.exp) report_mismatch("rdata", rdata, s.exp);
    if (s.op == op_read_delta && rdata !== last_read + s.exp) begin
      report_mismatch("rdata", rdata, last_read + s.exp);
    end
    if (s.op == op_bus_rd && bus_rdata !== s.exp) report_mismatch("bus_rdata", bus_rdata, s.exp);
    if (s.op == op_bus_delta && bus_rdata !== last_read + s.exp) begin
      report_mismatch("bus_rdata", bus_rdata, last_read + s.exp);
    end
    if (s.op == op_vec && trap_vector !== s.exp) report_mismatch("trap_vector", trap_vector, s.exp);
    if (s.op == op_epc && mepc_out !== s.exp) report_mismatch("mepc_out", mepc_out, s.exp);
    if (s.op == op_mode && mode !== s.exp[1:0]) report_mismatch("mode", {30'b0, mode}, s.exp);
    if (rden) last_read = rdata;
  endtask

  initial begin
    logic [31:0] base;
    logic [31:0] pc;
    logic [31:0] tval;
    void'($urandom(79));
    base = $urandom & 32'hffff_ff00;
    pc   = $urandom;
    tval = $urandom;
    clear_inputs();

    add_step(op_read, mtrap_pkg::csr_misa, 0, mtrap_pkg::misa_value);
    foreach (zero_addrs[i]) add_step(op_read, zero_addrs[i], 0, 0);
    add_readback(mtrap_pkg::csr_mscratch);
    add_readback(mtrap_pkg::csr_mtvec);
    add_readback(mtrap_pkg::csr_mepc);
    add_write_read(mtrap_pkg::csr_mstatus, 32'h1800, 32'h1800);
    add_write_read(mtrap_pkg::csr_mstatus, 32'h0800, 32'h1800); // mpp of 1 is dropped.
    add_write_read(mtrap_pkg::csr_mstatus, 32'h0000, 32'h0000);

    // counters.
    add_step(op_write, mtrap_pkg::csr_mcountinhibit, 1, 0);
    add_step(op_sample, mtrap_pkg::csr_mcycle, 0, 0);
    add_step(op_idle, 0, 0, 0);
    add_step(op_read_delta, mtrap_pkg::csr_mcycle, 0, 0);
    add_step(op_write, mtrap_pkg::csr_mcountinhibit, 0, 0);
    add_step(op_sample, mtrap_pkg::csr_minstret, 0, 0);
    repeat (3) add_step(op_valid, 0, 0, 0);
    add_step(op_read_delta, mtrap_pkg::csr_minstret, 0, 3);

    // ----------------------------------------
    // exception, then mret twice
    // ----------------------------------------
    add_step(op_write, mtrap_pkg::csr_mstatus, 32'h1808, 0);
    add_step(op_write, mtrap_pkg::csr_mtvec, base, 0);
    add_step(op_exc, 12'd2, pc, tval);
    add_step(op_idle, 0, 0, 0, 2'b01);
    add_step(op_read, mtrap_pkg::csr_mepc, 0, pc);
    add_step(op_epc, 0, 0, pc);
    add_step(op_read, mtrap_pkg::csr_mtval, 0, tval);
    add_step(op_read, mtrap_pkg::csr_mcause, 0, 32'd2);
    add_step(op_read, mtrap_pkg::csr_mstatus, 0, 32'h1880); // mpie set, mie clear.
    add_step(op_vec, 0, 0, base);
    add_step(op_mret, 0, 0, 0);
    add_step(op_idle, 0, 0, 0, 2'b10);
    add_step(op_read, mtrap_pkg::csr_mstatus, 0, 32'h0088);
    add_step(op_mode, 0, 0, 3);
    add_step(op_mret, 0, 0, 0);
    add_step(op_idle, 0, 0, 0, 2'b10);
    add_step(op_mode, 0, 0, 0); // mpp was user after the first mret.

    // timer interrupt through the clint.
    add_step(op_bus_wr, mtrap_pkg::clint_mtime_lo, 190, 0);
    add_step(op_bus_wr, mtrap_pkg::clint_mtimecmp_hi, 0, 0);
    add_step(op_bus_wr, mtrap_pkg::clint_mtimecmp_lo, 200, 0);
    add_step(op_bus_rd, mtrap_pkg::clint_mtimecmp_lo, 0, 200);
    add_step(op_write, mtrap_pkg::csr_mtvec, base | 32'd1, 0);
    add_step(op_write, mtrap_pkg::csr_mie, 32'h80, 0);
    add_step(op_write, mtrap_pkg::csr_mstatus, 32'h8, 0);
    add_step(op_wait_trap, 0, 0, 0);
    add_step(op_read, mtrap_pkg::csr_mcause, 0, {1'b1, 27'b0, mtrap_pkg::cause_m_timer});
    add_step(op_vec, 0, 0, base + 32'd28);
    add_step(op_mode, 0, 0, 3);

    // software interrupt, timer left pending but disabled.
    add_step(op_write, mtrap_pkg::csr_mie, 32'h8, 0);
    add_step(op_bus_wr, mtrap_pkg::clint_msip, 1, 0);
    add_step(op_bus_rd, mtrap_pkg::clint_msip, 0, 1);
    add_step(op_write, mtrap_pkg::csr_mstatus, 32'h8, 0);
    add_step(op_wait_trap, 0, 0, 0);
    add_step(op_read, mtrap_pkg::csr_mcause, 0, {1'b1, 27'b0, mtrap_pkg::cause_m_soft});
    add_step(op_vec, 0, 0, base + 32'd12);
    add_step(op_sample, mtrap_pkg::csr_time, 0, 0);
    add_step(op_bus_delta, mtrap_pkg::clint_mtime_lo, 0, 1); // one tick later.

    limit = steps.size() * 8 + 100;
    wait (rst === 1'b1);
    @(negedge clk);
    if (mode !== mtrap_pkg::mode_m) report_mismatch("mode", {30'b0, mode}, 32'd3);
    if (exc_taken !== 1'b0) report_mismatch("exc_taken", {31'b0, exc_taken}, 32'd0);
    if (mret_out !== 1'b0) report_mismatch("mret_out", {31'b0, mret_out}, 32'd0);
    foreach (steps[i]) run_step(steps[i]);

    $display("%0d steps run, %0d errors", steps.size(), errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: mtrap.f
hw/mtrap_pkg.sv
hw/clint.sv
hw/csr_file.sv
hw/mtrap_top.sv
tests/clock_gen.sv
tests/mtrap_tb.sv

// File: Bender.yml
package:
  name: mtrap

sources:
  - hw/mtrap_pkg.sv
  - hw/clint.sv
  - hw/csr_file.sv
  - hw/mtrap_top.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/mtrap_tb.sv
